// ==== hw/mem_pkg.sv ====
package mem_pkg;

    // address and data widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int BEAT_W = 64;
    localparam int LINE_W = 256;

    // line geometry
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;
    localparam int BEATS_PER_LINE = LINE_W / BEAT_W;
    localparam int OFFSET_W = 5;
    localparam int MASK_W = WORD_W / 8;

    // first fetch address out of reset
    localparam logic [ADDR_W-1:0] RESET_PC = 32'haaaaa000;

    // instruction queue
    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);

    // word 0 and beat 0 both sit in the low bits, i.e. the lowest address
    typedef union packed {
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;
        logic [BEATS_PER_LINE-1:0][BEAT_W-1:0] beats;
    } line_u;

endpackage

// ==== hw/burst_adapter.sv ====
`timescale 1ns/100ps

module burst_adapter import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              req_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic              write_i,
    input  line_u             wline_i,
    output logic              done_o,
    output line_u             rline_o,

    output logic [ADDR_W-1:0] bmem_addr_o,
    output logic              bmem_read_o,
    output logic              bmem_write_o,
    output logic [BEAT_W-1:0] bmem_wdata_o,
    input  logic              bmem_ready_i,
    input  logic [ADDR_W-1:0] bmem_raddr_i,
    input  logic [BEAT_W-1:0] bmem_rdata_i,
    input  logic              bmem_rvalid_i
);
    logic              rd_busy;
    logic              rd_sent;
    logic              wr_busy;
    logic [1:0]        beat_cnt;
    logic [ADDR_W-1:0] line_addr;
    logic              beat_in;

    assign line_addr = {addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // only beats tagged with our line count
    assign beat_in = rd_busy && rd_sent && bmem_rvalid_i && (bmem_raddr_i == line_addr);

    assign bmem_addr_o  = line_addr;
    assign bmem_read_o  = rd_busy && !rd_sent && bmem_ready_i;
    assign bmem_write_o = wr_busy;
    assign bmem_wdata_o = wline_i.beats[beat_cnt];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy  <= 1'b0;
            rd_sent  <= 1'b0;
            wr_busy  <= 1'b0;
            beat_cnt <= 2'd0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (rd_busy) begin
                if (bmem_read_o) begin
                    rd_sent <= 1'b1;
                end
                if (beat_in) begin
                    beat_cnt <= beat_cnt + 2'd1;
                    if (&beat_cnt) begin
                        rd_busy <= 1'b0;
                        done_o  <= 1'b1;
                    end
                end
            end else if (wr_busy) begin
                // beat taken on ready
                if (bmem_ready_i) begin
                    beat_cnt <= beat_cnt + 2'd1;
                    if (&beat_cnt) begin
                        wr_busy <= 1'b0;
                        done_o  <= 1'b1;
                    end
                end
            end else if (req_i && !done_o) begin
                // finished request is still on the inputs while done_o is high
                rd_busy  <= !write_i;
                wr_busy  <= write_i;
                rd_sent  <= 1'b0;
                beat_cnt <= 2'd0;
            end
        end
    end

    // beats return in address order
    always_ff @(posedge clk) begin
        if (beat_in) begin
            rline_o.beats[beat_cnt] <= bmem_rdata_i;
        end
    end

endmodule

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              f_req_i,
    input  logic [ADDR_W-1:0] f_addr_i,
    output logic              f_done_o,
    output line_u             f_rline_o,

    input  logic              d_req_i,
    input  logic [ADDR_W-1:0] d_addr_i,
    input  logic              d_write_i,
    input  line_u             d_wline_i,
    output logic              d_done_o,
    output line_u             d_rline_o,

    output logic              bus_req_o,
    output logic [ADDR_W-1:0] bus_addr_o,
    output logic              bus_write_o,
    output line_u             bus_wline_o,
    input  logic              bus_done_i,
    input  line_u             bus_rline_i
);
    logic busy;
    // set while the data port owns the bus
    logic owner_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            owner_d <= 1'b0;
        end else if (!busy) begin
            if (d_req_i) begin
                busy    <= 1'b1;
                owner_d <= 1'b1;
            end else if (f_req_i) begin
                busy    <= 1'b1;
                owner_d <= 1'b0;
            end
        end else if (bus_done_i) begin
            busy <= 1'b0;
        end
    end

    always_comb begin
        bus_req_o   = busy && (owner_d ? d_req_i : f_req_i);
        bus_addr_o  = owner_d ? d_addr_i : f_addr_i;
        // fetch never writes
        bus_write_o = busy && owner_d && d_write_i;
        bus_wline_o = d_wline_i;
        f_done_o    = busy && !owner_d && bus_done_i;
        d_done_o    = busy && owner_d && bus_done_i;
        f_rline_o   = '0;
        d_rline_o   = '0;
        if (owner_d) begin
            d_rline_o = bus_rline_i;
        end else begin
            f_rline_o = bus_rline_i;
        end
    end

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              redirect_i,
    input  logic [ADDR_W-1:0] redirect_pc_i,

    input  logic              queue_full_i,
    output logic              enq_o,
    output logic [ADDR_W-1:0] enq_pc_o,
    output logic [WORD_W-1:0] enq_instr_o,

    output logic              f_req_o,
    output logic [ADDR_W-1:0] f_addr_o,
    input  logic              f_done_i,
    input  line_u             f_rline_i
);
    logic [ADDR_W-1:0]        pc;
    line_u                    buf_line;
    logic [ADDR_W-1:OFFSET_W] buf_tag;
    logic                     buf_valid;
    logic                     discard;
    logic                     hit;
    logic                     start_miss;
    logic                     fill;

    assign hit = buf_valid && (buf_tag == pc[ADDR_W-1:OFFSET_W]);

    // no miss request while the pc is about to jump
    assign start_miss = !f_req_o && !hit && !redirect_i;
    assign fill       = f_req_o && f_done_i && !discard;

    // redirect flushes the queue this cycle, so nothing goes in
    assign enq_o       = hit && !queue_full_i && !redirect_i;
    assign enq_pc_o    = pc;
    assign enq_instr_o = buf_line.words[pc[OFFSET_W-1:2]];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= RESET_PC;
            buf_valid <= 1'b0;
            f_req_o   <= 1'b0;
            discard   <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc <= redirect_pc_i;
            end else if (enq_o) begin
                pc <= pc + ADDR_W'(4);
            end

            if (f_req_o) begin
                if (f_done_i) begin
                    f_req_o <= 1'b0;
                    discard <= 1'b0;
                    if (!discard) begin
                        buf_valid <= 1'b1;
                    end
                end else if (redirect_i) begin
                    // read in flight still completes, keep it only if it is the target line
                    discard <= redirect_pc_i[ADDR_W-1:OFFSET_W] !=
                               f_addr_o[ADDR_W-1:OFFSET_W];
                end
            end else if (start_miss) begin
                f_req_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_miss) begin
            f_addr_o <= {pc[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
        if (fill) begin
            buf_line <= f_rline_i;
            buf_tag  <= f_addr_o[ADDR_W-1:OFFSET_W];
        end
    end

endmodule

// ==== hw/instr_queue.sv ====
`timescale 1ns/100ps

module instr_queue import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush_i,

    input  logic              enq_i,
    input  logic [ADDR_W-1:0] enq_pc_i,
    input  logic [WORD_W-1:0] enq_instr_i,

    input  logic              deq_i,
    output logic              full_o,
    output logic              empty_o,
    output logic [ADDR_W-1:0] head_pc_o,
    output logic [WORD_W-1:0] head_instr_o
);
    logic [ADDR_W-1:0] pc_mem    [QUEUE_DEPTH];
    logic [WORD_W-1:0] instr_mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] head;
    logic [QPTR_W-1:0] tail;
    logic [QPTR_W:0]   count;
    logic              do_enq;
    logic              do_deq;

    // depth is a power of two, so full is the count msb
    assign full_o  = count[QPTR_W];
    assign empty_o = (count == '0);
    assign do_enq  = enq_i && !full_o && !flush_i;
    assign do_deq  = deq_i && !empty_o && !flush_i;

    assign head_pc_o    = pc_mem[head];
    assign head_instr_o = instr_mem[head];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_enq) begin
                tail <= tail + QPTR_W'(1);
            end
            if (do_deq) begin
                head <= head + QPTR_W'(1);
            end
            if (do_enq && !do_deq) begin
                count <= count + (QPTR_W + 1)'(1);
            end else if (do_deq && !do_enq) begin
                count <= count - (QPTR_W + 1)'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            pc_mem[tail]    <= enq_pc_i;
            instr_mem[tail] <= enq_instr_i;
        end
    end

endmodule

// ==== hw/data_port.sv ====
`timescale 1ns/100ps

module data_port import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic [ADDR_W-1:0] dmem_addr_i,
    input  logic [MASK_W-1:0] dmem_rmask_i,
    input  logic [MASK_W-1:0] dmem_wmask_i,
    input  logic [WORD_W-1:0] dmem_wdata_i,
    output logic [WORD_W-1:0] dmem_rdata_o,
    output logic              dmem_resp_o,

    output logic              d_req_o,
    output logic [ADDR_W-1:0] d_addr_o,
    output logic              d_write_o,
    output line_u             d_wline_o,
    input  logic              d_done_i,
    input  line_u             d_rline_i
);
    logic [OFFSET_W-3:0] word_idx;
    logic [WORD_W-1:0]   old_word;
    logic [WORD_W-1:0]   load_word;
    logic [WORD_W-1:0]   store_word;
    line_u               merged;
    logic                is_store;
    logic                read_done;

    assign word_idx  = dmem_addr_i[OFFSET_W-1:2];
    assign old_word  = d_rline_i.words[word_idx];
    assign is_store  = |dmem_wmask_i;
    assign read_done = d_req_o && d_done_i && !d_write_o;

    // byte lanes for load masking and store merge
    always_comb begin
        for (int i = 0; i < MASK_W; i++) begin
            load_word[8*i +: 8]  = dmem_rmask_i[i] ? old_word[8*i +: 8] : 8'h00;
            store_word[8*i +: 8] = dmem_wmask_i[i] ? dmem_wdata_i[8*i +: 8] : old_word[8*i +: 8];
        end
        merged                 = d_rline_i;
        merged.words[word_idx] = store_word;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            d_req_o     <= 1'b0;
            d_write_o   <= 1'b0;
            dmem_resp_o <= 1'b0;
        end else begin
            dmem_resp_o <= 1'b0;
            if (!d_req_o) begin
                // request is still held during the response cycle
                if ((|dmem_rmask_i || is_store) && !dmem_resp_o) begin
                    d_req_o <= 1'b1;
                end
            end else if (d_done_i) begin
                if (is_store && !d_write_o) begin
                    // keep req up, the write-back follows
                    d_write_o <= 1'b1;
                end else begin
                    d_req_o     <= 1'b0;
                    d_write_o   <= 1'b0;
                    dmem_resp_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!d_req_o) begin
            d_addr_o <= {dmem_addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        end
        if (read_done) begin
            dmem_rdata_o <= load_word;
            d_wline_o    <= merged;
        end
    end

endmodule

// ==== hw/mem_system.sv ====
`timescale 1ns/100ps

module mem_system import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              redirect_i,
    input  logic [ADDR_W-1:0] redirect_pc_i,
    input  logic              instr_deq_i,
    output logic              instr_empty_o,
    output logic [WORD_W-1:0] instr_o,
    output logic [ADDR_W-1:0] instr_pc_o,

    input  logic [ADDR_W-1:0] dmem_addr_i,
    input  logic [MASK_W-1:0] dmem_rmask_i,
    input  logic [MASK_W-1:0] dmem_wmask_i,
    input  logic [WORD_W-1:0] dmem_wdata_i,
    output logic [WORD_W-1:0] dmem_rdata_o,
    output logic              dmem_resp_o,

    output logic [ADDR_W-1:0] bmem_addr_o,
    output logic              bmem_read_o,
    output logic              bmem_write_o,
    output logic [BEAT_W-1:0] bmem_wdata_o,
    input  logic              bmem_ready_i,
    input  logic [ADDR_W-1:0] bmem_raddr_i,
    input  logic [BEAT_W-1:0] bmem_rdata_i,
    input  logic              bmem_rvalid_i
);
    // fetch to queue
    logic              enq;
    logic [ADDR_W-1:0] enq_pc;
    logic [WORD_W-1:0] enq_instr;
    logic              queue_full;

    // fetch line requests
    logic              f_req;
    logic [ADDR_W-1:0] f_addr;
    logic              f_done;
    line_u             f_rline;

    // data line requests
    logic              d_req;
    logic [ADDR_W-1:0] d_addr;
    logic              d_write;
    line_u             d_wline;
    logic              d_done;
    line_u             d_rline;

    // granted request into the burst adapter
    logic              bus_req;
    logic [ADDR_W-1:0] bus_addr;
    logic              bus_write;
    line_u             bus_wline;
    logic              bus_done;
    line_u             bus_rline;

    fetch_unit u_fetch_unit (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .queue_full_i  (queue_full),
        .enq_o         (enq),
        .enq_pc_o      (enq_pc),
        .enq_instr_o   (enq_instr),
        .f_req_o       (f_req),
        .f_addr_o      (f_addr),
        .f_done_i      (f_done),
        .f_rline_i     (f_rline)
    );

    instr_queue u_instr_queue (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (redirect_i),
        .enq_i        (enq),
        .enq_pc_i     (enq_pc),
        .enq_instr_i  (enq_instr),
        .deq_i        (instr_deq_i),
        .full_o       (queue_full),
        .empty_o      (instr_empty_o),
        .head_pc_o    (instr_pc_o),
        .head_instr_o (instr_o)
    );

    data_port u_data_port (
        .clk          (clk),
        .rst          (rst),
        .dmem_addr_i  (dmem_addr_i),
        .dmem_rmask_i (dmem_rmask_i),
        .dmem_wmask_i (dmem_wmask_i),
        .dmem_wdata_i (dmem_wdata_i),
        .dmem_rdata_o (dmem_rdata_o),
        .dmem_resp_o  (dmem_resp_o),
        .d_req_o      (d_req),
        .d_addr_o     (d_addr),
        .d_write_o    (d_write),
        .d_wline_o    (d_wline),
        .d_done_i     (d_done),
        .d_rline_i    (d_rline)
    );

    mem_arbiter u_mem_arbiter (
        .clk         (clk),
        .rst         (rst),
        .f_req_i     (f_req),
        .f_addr_i    (f_addr),
        .f_done_o    (f_done),
        .f_rline_o   (f_rline),
        .d_req_i     (d_req),
        .d_addr_i    (d_addr),
        .d_write_i   (d_write),
        .d_wline_i   (d_wline),
        .d_done_o    (d_done),
        .d_rline_o   (d_rline),
        .bus_req_o   (bus_req),
        .bus_addr_o  (bus_addr),
        .bus_write_o (bus_write),
        .bus_wline_o (bus_wline),
        .bus_done_i  (bus_done),
        .bus_rline_i (bus_rline)
    );

    burst_adapter u_burst_adapter (
        .clk           (clk),
        .rst           (rst),
        .req_i         (bus_req),
        .addr_i        (bus_addr),
        .write_i       (bus_write),
        .wline_i       (bus_wline),
        .done_o        (bus_done),
        .rline_o       (bus_rline),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_write_o  (bmem_write_o),
        .bmem_wdata_o  (bmem_wdata_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

endmodule

// ==== sim/clk_gen.sv ====
`timescale 1ns/100ps

module clk_gen (
    output logic clk_o
);
    // 40 ns period
    localparam int HALF_PERIOD = 20;

    initial clk_o = 1'b0;

    always #HALF_PERIOD clk_o = ~clk_o;

endmodule

// ==== sim/bmem_model.sv ====
`timescale 1ns/100ps

module bmem_model import mem_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] bmem_addr_i,
    input  logic              bmem_read_i,
    input  logic              bmem_write_i,
    input  logic [BEAT_W-1:0] bmem_wdata_i,
    output logic              bmem_ready_o,
    output logic [ADDR_W-1:0] bmem_raddr_o,
    output logic [BEAT_W-1:0] bmem_rdata_o,
    output logic              bmem_rvalid_o
);
    // 8 KB window, addresses alias above it
    localparam int MEM_BEATS = 1024;

    logic [BEAT_W-1:0] mem [MEM_BEATS];
    logic [ADDR_W-1:0] pending [$];
    logic [1:0]        rd_beat;
    logic [1:0]        wr_beat;
    integer            seed;

    function automatic int beat_index(input logic [ADDR_W-1:0] addr);
        return int'(addr[12:3]);
    endfunction

    // backdoor read, word 0 in the low half of a beat
    function automatic logic [WORD_W-1:0] peek_word(input logic [ADDR_W-1:0] addr);
        logic [BEAT_W-1:0] beat;
        beat = mem[beat_index(addr)];
        return addr[2] ? beat[BEAT_W-1:WORD_W] : beat[WORD_W-1:0];
    endfunction

    initial begin
        seed          = 32'h511e26ae;
        bmem_ready_o  = 1'b0;
        bmem_rvalid_o = 1'b0;
        bmem_raddr_o  = '0;
        bmem_rdata_o  = '0;
        for (int i = 0; i < MEM_BEATS; i++) begin
            mem[i] = {$random(seed), $random(seed)};
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            pending.delete();
            rd_beat <= 2'd0;
            wr_beat <= 2'd0;
        end else begin
            if (bmem_read_i) begin
                pending.push_back(bmem_addr_i);
            end
            if (bmem_write_i && bmem_ready_o) begin
                mem[beat_index(bmem_addr_i) + int'(wr_beat)] <= bmem_wdata_i;
                wr_beat <= wr_beat + 2'd1;
            end
            if (bmem_rvalid_o) begin
                rd_beat <= rd_beat + 2'd1;
                if (rd_beat == 2'd3) begin
                    void'(pending.pop_front());
                end
            end
        end
    end

    // outputs change away from the sampling edge
    always @(negedge clk) begin
        bmem_ready_o  <= ($random(seed) & 3) != 0;
        bmem_rvalid_o <= 1'b0;
        if (!rst && pending.size() != 0 && ($random(seed) & 1) == 1) begin
            bmem_rvalid_o <= 1'b1;
            bmem_raddr_o  <= pending[0];
            bmem_rdata_o  <= mem[beat_index(pending[0]) + int'(rd_beat)];
        end
    end

endmodule

// ==== sim/mem_system_properties.sv ====
`timescale 1ns/100ps

module mem_system_properties import mem_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              bmem_read_i,
    input logic              bmem_write_i,
    input logic [ADDR_W-1:0] bmem_addr_i,
    input logic              dmem_resp_i
);

    a_no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read_i && bmem_write_i))
        else $error("bmem read and write strobes high in the same cycle");

    // write burst keeps one address for all beats
    a_write_addr_stable: assert property (@(posedge clk) disable iff (rst)
        bmem_write_i && $past(bmem_write_i) |-> $stable(bmem_addr_i))
        else $error("bmem address changed during a write burst");

    a_resp_single_cycle: assert property (@(posedge clk) disable iff (rst)
        dmem_resp_i |=> !dmem_resp_i)
        else $error("dmem response held for more than one cycle");

    a_quiet_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !bmem_read_i && !bmem_write_i && !dmem_resp_i)
        else $error("strobe active during reset");

endmodule

bind mem_system mem_system_properties u_mem_system_properties (
    .clk          (clk),
    .rst          (rst),
    .bmem_read_i  (bmem_read_o),
    .bmem_write_i (bmem_write_o),
    .bmem_addr_i  (bmem_addr_o),
    .dmem_resp_i  (dmem_resp_o)
);

// ==== sim/tb_mem_system.sv ====
`timescale 1ns/100ps

module tb_mem_system import mem_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 600;

    // cycle budget of each test, the watchdog uses the sum
    localparam int BUDGET_SEQ      = 1500;
    localparam int BUDGET_BACKPR   = 1500;
    localparam int BUDGET_REDIRECT = 1500;
    localparam int BUDGET_LOADS    = 1500;
    localparam int BUDGET_STORE    = 1000;
    localparam int BUDGET_SHARED   = 4000;
    localparam int BUDGET_TOTAL    = RESET_CYCLES + BUDGET_SEQ + BUDGET_BACKPR +
                                     BUDGET_REDIRECT + BUDGET_LOADS + BUDGET_STORE +
                                     BUDGET_SHARED;

    // fetch stays below 0xaaaab000, data above
    localparam logic [ADDR_W-1:0] REDIRECT_PC = 32'haaaaa50c;
    localparam logic [ADDR_W-1:0] LOAD_BASE   = 32'haaaab000;
    localparam logic [ADDR_W-1:0] STORE_ADDR  = 32'haaaab048;
    localparam logic [WORD_W-1:0] STORE_DATA  = 32'h1234_5678;
    localparam logic [ADDR_W-1:0] MIX_BASE    = 32'haaaab400;

    logic              clk;
    logic              rst;
    logic              redirect_i;
    logic [ADDR_W-1:0] redirect_pc_i;
    logic              instr_deq_i;
    logic              instr_empty_o;
    logic [WORD_W-1:0] instr_o;
    logic [ADDR_W-1:0] instr_pc_o;
    logic [ADDR_W-1:0] dmem_addr_i;
    logic [MASK_W-1:0] dmem_rmask_i;
    logic [MASK_W-1:0] dmem_wmask_i;
    logic [WORD_W-1:0] dmem_wdata_i;
    logic [WORD_W-1:0] dmem_rdata_o;
    logic              dmem_resp_o;
    logic [ADDR_W-1:0] bmem_addr;
    logic              bmem_read;
    logic              bmem_write;
    logic [BEAT_W-1:0] bmem_wdata;
    logic              bmem_ready;
    logic [ADDR_W-1:0] bmem_raddr;
    logic [BEAT_W-1:0] bmem_rdata;
    logic              bmem_rvalid;

    int                errors;
    int                errors_at_start;
    int                tests_run;
    int                tests_bad;
    string             cur_test;
    logic [ADDR_W-1:0] next_pc;

    clk_gen u_clk_gen (
        .clk_o (clk)
    );

    bmem_model u_bmem (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_i   (bmem_addr),
        .bmem_read_i   (bmem_read),
        .bmem_write_i  (bmem_write),
        .bmem_wdata_i  (bmem_wdata),
        .bmem_ready_o  (bmem_ready),
        .bmem_raddr_o  (bmem_raddr),
        .bmem_rdata_o  (bmem_rdata),
        .bmem_rvalid_o (bmem_rvalid)
    );

    mem_system u_mem_system (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .instr_deq_i   (instr_deq_i),
        .instr_empty_o (instr_empty_o),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .dmem_addr_i   (dmem_addr_i),
        .dmem_rmask_i  (dmem_rmask_i),
        .dmem_wmask_i  (dmem_wmask_i),
        .dmem_wdata_i  (dmem_wdata_i),
        .dmem_rdata_o  (dmem_rdata_o),
        .dmem_resp_o   (dmem_resp_o),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_write_o  (bmem_write),
        .bmem_wdata_o  (bmem_wdata),
        .bmem_ready_i  (bmem_ready),
        .bmem_raddr_i  (bmem_raddr),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid)
    );

    task automatic check_word(input string what, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string what, input logic [ADDR_W-1:0] exp,
                              input logic [ADDR_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("ERROR %s: %s", cur_test, msg);
        errors++;
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d checks wrong", cur_test, errors - errors_at_start);
            tests_bad++;
        end
    endtask

    // byte mask widened to one bit per data bit
    function automatic logic [WORD_W-1:0] byte_lanes(input logic [MASK_W-1:0] mask);
        logic [WORD_W-1:0] lanes;
        for (int i = 0; i < MASK_W; i++) begin
            lanes[8*i +: 8] = {8{mask[i]}};
        end
        return lanes;
    endfunction

    // called on a falling edge, leaves deq high after a pop
    task automatic pop_instr(output logic [ADDR_W-1:0] pc, output logic [WORD_W-1:0] instr,
                             output logic ok);
        int waited;
        waited = 0;
        while (instr_empty_o && waited < WAIT_LIMIT) begin
            instr_deq_i = 1'b0;
            @(negedge clk);
            waited++;
        end
        ok = !instr_empty_o;
        pc = instr_pc_o;
        instr = instr_o;
        if (!ok) begin
            report_problem($sformatf("instruction queue stayed empty for %0d cycles", waited));
        end else begin
            instr_deq_i = 1'b1;
            @(negedge clk);
        end
    endtask

    task automatic expect_next_instr();
        logic [ADDR_W-1:0] pc;
        logic [WORD_W-1:0] instr;
        logic              ok;
        pop_instr(pc, instr, ok);
        if (ok) begin
            check_addr("pc", next_pc, pc);
            check_word($sformatf("instr at %h", next_pc), u_bmem.peek_word(next_pc), instr);
        end
        next_pc = next_pc + ADDR_W'(4);
    endtask

    task automatic pop_stream(input int count);
        repeat (count) begin
            expect_next_instr();
        end
        instr_deq_i = 1'b0;
    endtask

    // holds the request until the response pulse
    task automatic data_access(input logic [ADDR_W-1:0] addr, input logic [MASK_W-1:0] rmask,
                               input logic [MASK_W-1:0] wmask, input logic [WORD_W-1:0] wdata,
                               output logic [WORD_W-1:0] rdata);
        int waited;
        waited       = 0;
        dmem_addr_i  = addr;
        dmem_rmask_i = rmask;
        dmem_wmask_i = wmask;
        dmem_wdata_i = wdata;
        @(negedge clk);
        while (!dmem_resp_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!dmem_resp_o) begin
            report_problem($sformatf("no dmem response for address %h", addr));
        end
        rdata        = dmem_rdata_o;
        dmem_rmask_i = '0;
        dmem_wmask_i = '0;
    endtask

    task automatic sequential_fetch();
        begin_test("sequential fetch");
        if (!instr_empty_o) begin
            report_problem("instruction queue not empty right after reset");
        end
        next_pc = RESET_PC;
        pop_stream(3 * WORDS_PER_LINE);
        end_test();
    endtask

    task automatic fetch_backpressure();
        int waited;
        begin_test("back-pressure");
        waited = 0;
        while (!u_mem_system.queue_full && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!u_mem_system.queue_full) begin
            report_problem("instruction queue never filled");
        end
        // fetch has to hold while nothing drains
        repeat (20) @(negedge clk);
        pop_stream(QUEUE_DEPTH + WORDS_PER_LINE);
        end_test();
    endtask

    task automatic fetch_redirect();
        begin_test("redirect");
        pop_stream(3);
        redirect_pc_i = REDIRECT_PC;
        redirect_i    = 1'b1;
        @(negedge clk);
        redirect_i = 1'b0;
        next_pc    = REDIRECT_PC;
        pop_stream(2 * WORDS_PER_LINE);
        end_test();
    endtask

    task automatic masked_loads();
        logic [MASK_W-1:0] masks [5];
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] rdata;
        begin_test("masked loads");
        masks = '{4'b0001, 4'b0100, 4'b0011, 4'b1100, 4'b1111};
        for (int i = 0; i < 5; i++) begin
            addr = LOAD_BASE + ADDR_W'(36 * i);
            data_access(addr, masks[i], '0, '0, rdata);
            check_word($sformatf("load %h mask %b", addr, masks[i]),
                       u_bmem.peek_word(addr) & byte_lanes(masks[i]), rdata);
        end
        end_test();
    endtask

    task automatic store_merge();
        logic [ADDR_W-1:0] line_addr;
        logic [WORD_W-1:0] old_words [WORDS_PER_LINE];
        logic [WORD_W-1:0] lanes;
        logic [WORD_W-1:0] merged;
        logic [WORD_W-1:0] exp;
        logic [WORD_W-1:0] rdata;
        int                widx;
        begin_test("store merge");
        line_addr = {STORE_ADDR[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            old_words[w] = u_bmem.peek_word(line_addr + ADDR_W'(4 * w));
        end
        widx   = int'(STORE_ADDR[OFFSET_W-1:2]);
        lanes  = byte_lanes(4'b0110);
        merged = (old_words[widx] & ~lanes) | (STORE_DATA & lanes);
        data_access(STORE_ADDR, '0, 4'b0110, STORE_DATA, rdata);
        data_access(STORE_ADDR, 4'b1111, '0, '0, rdata);
        check_word("load after store", merged, rdata);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            exp = (w == widx) ? merged : old_words[w];
            check_word($sformatf("backdoor word %0d", w), exp,
                       u_bmem.peek_word(line_addr + ADDR_W'(4 * w)));
        end
        end_test();
    endtask

    task automatic mixed_data_traffic();
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        logic [WORD_W-1:0] rdata;
        for (int i = 0; i < 4; i++) begin
            addr  = MIX_BASE + ADDR_W'(100 * i);
            wdata = 32'h5a00_0000 | WORD_W'(i * 32'h0101);
            data_access(addr, 4'b1111, '0, '0, rdata);
            check_word($sformatf("load %h", addr), u_bmem.peek_word(addr), rdata);
            data_access(addr, '0, 4'b1111, wdata, rdata);
            data_access(addr, 4'b1111, '0, '0, rdata);
            check_word($sformatf("reload %h", addr), wdata, rdata);
        end
    endtask

    task automatic shared_bus_traffic();
        begin_test("data with fetch misses");
        fork
            pop_stream(4 * WORDS_PER_LINE);
            mixed_data_traffic();
        join
        end_test();
    endtask

    initial begin
        #(BUDGET_TOTAL * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", BUDGET_TOTAL);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        errors        = 0;
        tests_run     = 0;
        tests_bad     = 0;
        rst           = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        instr_deq_i   = 1'b0;
        dmem_addr_i   = '0;
        dmem_rmask_i  = '0;
        dmem_wmask_i  = '0;
        dmem_wdata_i  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        sequential_fetch();
        fetch_backpressure();
        fetch_redirect();
        masked_loads();
        store_merge();
        shared_bus_traffic();

        $display("summary: %0d tests run, %0d with errors, %0d failed checks",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hw/mem_pkg.sv
hw/burst_adapter.sv
hw/mem_arbiter.sv
hw/fetch_unit.sv
hw/instr_queue.sv
hw/data_port.sv
hw/mem_system.sv
sim/clk_gen.sv
sim/bmem_model.sv
sim/mem_system_properties.sv
sim/tb_mem_system.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then decide from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mem_system -f sources.f \
    -Mdir obj_dir -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0
